/* hdl/fm_config.svh */
// Every channel data width must stay below FM_AXI_DW and the spy depth is always a power of two
`ifndef FM_CONFIG_SVH
`define FM_CONFIG_SVH

// control port
`define FM_AXI_DW 32 // control word width

// spy memory geometry
`define FM_SB_ADDR_W 4 // spy address bits
`define FM_SB_DEPTH (1 << `FM_SB_ADDR_W) // words per spy buffer

// channel map
`define FM_HIT_CH 2 // hit channels come first
`define FM_SEG_CH 2 // segment channels follow the hits
`define FM_CH (`FM_HIT_CH + `FM_SEG_CH) // all spied channels

// payload widths
`define FM_HIT_DW 24 // hit word width
`define FM_SEG_DW 16 // segment word width

// word written everywhere by the fill sequencer
`define FM_INIT_PATTERN 32'h0fa5fa50

`endif

/* hdl/fm_pkg.sv */
// Struct layouts follow fm_config.svh and the valid flag is always a single bit ahead of data
`include "fm_config.svh"

package fm_pkg;

	// monitor word of a hit channel
	typedef struct packed
	{
		logic vld; // word present this cycle
		logic [`FM_HIT_DW-1:0] data; // hit payload
	} hit_rt_t; // 25 bits

	// monitor word of a segment channel
	typedef struct packed
	{
		logic vld; // word present this cycle
		logic [`FM_SEG_DW-1:0] data; // segment payload
	} seg_rt_t; // 17 bits

	// one control access, taken whenever enable is high
	typedef struct packed
	{
		logic enable; // access strobe
		logic wr_enable; // 1 write, 0 read
		logic [`FM_SB_ADDR_W-1:0] address; // spy location
		logic [`FM_AXI_DW-1:0] wr_data; // truncated to channel width on write
	} spy_ctrl_t; // 38 bits

	// read reply, one cycle after the read access
	typedef struct packed
	{
		logic [`FM_AXI_DW-1:0] rd_data; // zero extended, 0 when no reply
		logic rd_data_valid; // reply strobe
	} spy_mon_t; // 33 bits

endpackage

/* hdl/spy_buffer.sv */
// Payload type needs vld and data fields and its data must be narrower than FM_AXI_DW
`timescale 1ns/1ps
`include "fm_config.svh"

module spy_buffer #(
	parameter type payload_t = fm_pkg::hit_rt_t // hit or segment word
)(
	input logic spy_clock,
	input logic axi_reset_n, // sync, active low
	input payload_t mon_i, // monitored word
	input logic freeze_i, // stop recording, passthrough keeps going
	input fm_pkg::spy_ctrl_t ctrl_i, // control access
	output payload_t pass_o, // monitored word one cycle later
	output fm_pkg::spy_mon_t rd_o // read reply
);
	import fm_pkg::*;

	localparam int DW = $bits(mon_i.data); // stored word width
	localparam int AXI_DW = `FM_AXI_DW;
	localparam int ADDR_W = `FM_SB_ADDR_W;
	localparam int DEPTH = `FM_SB_DEPTH;

	// passthrough stage
	logic pass_vld_q; // cleared by reset
	logic [DW-1:0] pass_data_q; // payload only

	// spy memory and its circular pointer
	logic [DW-1:0] mem_q [DEPTH]; // spy words
	logic [ADDR_W-1:0] wr_ptr_q; // next capture slot

	// read side
	logic rd_vld_q; // reply due this cycle
	logic [DW-1:0] rd_data_q; // word fetched last cycle
	spy_mon_t rd_reply; // assembled reply

	logic ctrl_wr; // control write this cycle
	logic ctrl_rd; // control read this cycle
	logic capture; // monitor word goes into memory

	assign ctrl_wr = ctrl_i.enable & ctrl_i.wr_enable;
	assign ctrl_rd = ctrl_i.enable & ~ctrl_i.wr_enable;
	assign capture = mon_i.vld & ~freeze_i & ~ctrl_wr; // control write has the port

	// one register stage, freeze has no say here
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			pass_vld_q <= 1'b0;
		end
		else
		begin
			pass_vld_q <= mon_i.vld;
		end
	end

	always_ff @(posedge spy_clock)
	begin
		pass_data_q <= mon_i.data; // follows input every cycle
	end

	always_comb
	begin
		pass_o = '0;
		pass_o.vld = pass_vld_q;
		pass_o.data = pass_data_q;
	end

	// single write port shared by control and capture
	always_ff @(posedge spy_clock)
	begin
		if (ctrl_wr)
		begin
			mem_q[ctrl_i.address] <= ctrl_i.wr_data[DW-1:0]; // truncate to channel
		end
		else if (capture)
		begin
			mem_q[wr_ptr_q] <= mon_i.data;
		end
	end

	// pointer moves only on capture, fill writes leave it alone
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			wr_ptr_q <= '0;
		end
		else if (capture)
		begin
			wr_ptr_q <= wr_ptr_q + 1'b1; // wraps at depth
		end
	end

	// reply strobe exactly one cycle after the read
	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			rd_vld_q <= 1'b0;
		end
		else
		begin
			rd_vld_q <= ctrl_rd;
		end
	end

	always_ff @(posedge spy_clock)
	begin
		if (ctrl_rd)
		begin
			rd_data_q <= mem_q[ctrl_i.address]; // old word if capture hits same slot
		end
	end

	// data is forced to zero outside a reply
	always_comb
	begin
		rd_reply.rd_data_valid = rd_vld_q;
		rd_reply.rd_data = rd_vld_q ? AXI_DW'(rd_data_q) : '0; // zero extend
	end

	assign rd_o = rd_reply;

endmodule

/* hdl/spy_mem_init.sv */
// Fill takes FM_SB_DEPTH cycles plus one and a request must drop after ack before the next fill
`timescale 1ns/1ps
`include "fm_config.svh"

module spy_mem_init (
	input logic spy_clock,
	input logic axi_reset_n, // sync, active low
	input logic init_req_i, // held high until ack
	output logic init_ack_o, // high until req drops
	input fm_pkg::spy_ctrl_t ctrl_i [`FM_CH], // external accesses
	output fm_pkg::spy_ctrl_t ctrl_o [`FM_CH] // accesses seen by the buffers
);
	import fm_pkg::*;

	localparam int ADDR_W = `FM_SB_ADDR_W;
	localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(`FM_SB_DEPTH - 1);

	typedef enum logic [1:0]
	{
		ST_IDLE, // pass external accesses
		ST_FILL, // one pattern write per cycle
		ST_ACK // wait for req low
	} init_state_t;

	init_state_t state_q; // sequencer state
	logic [ADDR_W-1:0] fill_addr_q; // address being filled
	spy_ctrl_t fill_ctrl; // pattern write shared by all channels

	always_ff @(posedge spy_clock)
	begin
		if (!axi_reset_n)
		begin
			state_q <= ST_IDLE;
			fill_addr_q <= '0;
		end
		else
		begin
			case (state_q)
				ST_IDLE:
				begin
					fill_addr_q <= '0;
					if (init_req_i)
						state_q <= ST_FILL;
				end
				ST_FILL:
				begin
					fill_addr_q <= fill_addr_q + 1'b1;
					if (fill_addr_q == LAST_ADDR)
						state_q <= ST_ACK; // last location written this cycle
				end
				ST_ACK:
				begin
					if (!init_req_i)
						state_q <= ST_IDLE; // ack drops on this edge
				end
				default:
				begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	assign init_ack_o = (state_q == ST_ACK);

	always_comb
	begin
		fill_ctrl.enable = 1'b1;
		fill_ctrl.wr_enable = 1'b1; // write, so no read reply
		fill_ctrl.address = fill_addr_q;
		fill_ctrl.wr_data = `FM_INIT_PATTERN;
	end

	// external accesses are dropped while filling
	always_comb
	begin
		for (int ch = 0; ch < `FM_CH; ch++)
		begin
			ctrl_o[ch] = (state_q == ST_FILL) ? fill_ctrl : ctrl_i[ch];
		end
	end

endmodule

/* hdl/fm_data.sv */
// Hit channels take indices 0 to FM_HIT_CH-1 and segment channels follow on all channel arrays
`timescale 1ns/1ps
`include "fm_config.svh"

module fm_data (
	input logic spy_clock,
	input logic axi_reset_n, // sync, active low
	input logic [`FM_CH-1:0] freeze_i, // per channel freeze
	input logic init_req_i, // fill request
	output logic init_ack_o, // fill done
	input fm_pkg::spy_ctrl_t ctrl_i [`FM_CH], // control access per channel
	input fm_pkg::hit_rt_t mon_hit_i [`FM_HIT_CH], // hit monitor words
	input fm_pkg::seg_rt_t mon_seg_i [`FM_SEG_CH], // segment monitor words
	output fm_pkg::hit_rt_t pass_hit_o [`FM_HIT_CH], // hit passthrough
	output fm_pkg::seg_rt_t pass_seg_o [`FM_SEG_CH], // segment passthrough
	output fm_pkg::spy_mon_t spy_rd_o [`FM_CH] // read replies
);
	import fm_pkg::*;

	spy_ctrl_t buf_ctrl [`FM_CH]; // after fill override

	// decides who owns the control ports
	spy_mem_init u_mem_init
	(
		.spy_clock (spy_clock),
		.axi_reset_n (axi_reset_n),
		.init_req_i (init_req_i),
		.init_ack_o (init_ack_o),
		.ctrl_i (ctrl_i),
		.ctrl_o (buf_ctrl)
	);

	// hit channels
	generate
		for (genvar h = 0; h < `FM_HIT_CH; h++)
		begin : g_hit
			spy_buffer #(
				.payload_t (hit_rt_t)
			) u_hit_sb
			(
				.spy_clock (spy_clock),
				.axi_reset_n (axi_reset_n),
				.mon_i (mon_hit_i[h]),
				.freeze_i (freeze_i[h]),
				.ctrl_i (buf_ctrl[h]),
				.pass_o (pass_hit_o[h]),
				.rd_o (spy_rd_o[h])
			);
		end
	endgenerate

	// segment channels sit after the hits
	generate
		for (genvar s = 0; s < `FM_SEG_CH; s++)
		begin : g_seg
			spy_buffer #(
				.payload_t (seg_rt_t)
			) u_seg_sb
			(
				.spy_clock (spy_clock),
				.axi_reset_n (axi_reset_n),
				.mon_i (mon_seg_i[s]),
				.freeze_i (freeze_i[`FM_HIT_CH + s]),
				.ctrl_i (buf_ctrl[`FM_HIT_CH + s]),
				.pass_o (pass_seg_o[s]),
				.rd_o (spy_rd_o[`FM_HIT_CH + s])
			);
		end
	endgenerate

endmodule

/* verif/fm_data_tb.sv */
// Needs assertion support enabled, stops at the first mismatch and checks the fill by read back only
`timescale 1ns/1ps
`include "fm_config.svh"

module fm_data_tb;
	import fm_pkg::*;

	localparam int CH = `FM_CH;
	localparam int HIT = `FM_HIT_CH;
	localparam int SEG = `FM_SEG_CH;
	localparam int DEPTH = `FM_SB_DEPTH;
	localparam int ADDR_W = `FM_SB_ADDR_W;
	localparam int TIMEOUT = 100; // cycles allowed for the fill

	logic spy_clock;
	logic axi_reset_n;
	logic [CH-1:0] freeze_i;
	logic init_req_i;
	logic init_ack_o;
	spy_ctrl_t ctrl_i [CH];
	hit_rt_t mon_hit_i [HIT];
	seg_rt_t mon_seg_i [SEG];
	hit_rt_t pass_hit_o [HIT];
	seg_rt_t pass_seg_o [SEG];
	spy_mon_t spy_rd_o [CH];

	logic [31:0] mem_model [CH][DEPTH]; // expected spy contents
	int ptr_model [CH]; // expected write pointer
	logic drv_vld [CH]; // monitor word per channel
	logic [31:0] drv_data [CH];
	logic rd_pend [CH]; // reply due at next check
	logic [31:0] rd_exp [CH];
	logic pass_chk; // passthrough compare on
	logic fill_active; // model ignores control while filling

	fm_data DUT
	(
		.spy_clock (spy_clock),
		.axi_reset_n (axi_reset_n),
		.freeze_i (freeze_i),
		.init_req_i (init_req_i),
		.init_ack_o (init_ack_o),
		.ctrl_i (ctrl_i),
		.mon_hit_i (mon_hit_i),
		.mon_seg_i (mon_seg_i),
		.pass_hit_o (pass_hit_o),
		.pass_seg_o (pass_seg_o),
		.spy_rd_o (spy_rd_o)
	);

	initial spy_clock = 1'b0;
	always #5 spy_clock = ~spy_clock; // 10 ns period

	task automatic fail_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at first error");
	endtask

	// reply data must be zero outside a reply
	for (genvar c = 0; c < CH; c++)
	begin : g_rd_zero
		assert property (@(posedge spy_clock) disable iff (!axi_reset_n)
			!spy_rd_o[c].rd_data_valid |-> spy_rd_o[c].rd_data == '0)
		else
		begin
			$display("ERR spy_rd_o[%0d].rd_data: got 0x%h expected 0x00000000", c,
				spy_rd_o[c].rd_data);
			fail_run();
		end
	end

	function automatic logic [31:0] chan_mask(input int c);
		if (c < HIT)
			return (32'h1 << `FM_HIT_DW) - 32'h1; // hit width
		return (32'h1 << `FM_SEG_DW) - 32'h1; // segment width
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("ERR %s: got 0x%h expected 0x%h", name, got, exp);
			fail_run();
		end
	endtask

	// falling edge, outputs settled since the last rising edge
	task automatic tick();
		@(negedge spy_clock);
		for (int c = 0; c < CH; c++)
		begin
			check_val($sformatf("spy_rd_o[%0d].rd_data_valid", c),
				32'(spy_rd_o[c].rd_data_valid), 32'(rd_pend[c]));
			if (rd_pend[c])
				check_val($sformatf("spy_rd_o[%0d].rd_data", c), spy_rd_o[c].rd_data, rd_exp[c]);
			rd_pend[c] = 1'b0;
		end
		if (pass_chk)
		begin
			for (int h = 0; h < HIT; h++)
				check_val($sformatf("pass_hit_o[%0d]", h), 32'(pass_hit_o[h]), 32'(mon_hit_i[h]));
			for (int s = 0; s < SEG; s++)
				check_val($sformatf("pass_seg_o[%0d]", s), 32'(pass_seg_o[s]), 32'(mon_seg_i[s]));
		end
	endtask

	task automatic clear_ctrl();
		for (int c = 0; c < CH; c++)
			ctrl_i[c] = '0;
	endtask

	task automatic set_ctrl(input int c, input logic wr, input logic [ADDR_W-1:0] addr,
		input logic [31:0] data);
		ctrl_i[c].enable = 1'b1;
		ctrl_i[c].wr_enable = wr;
		ctrl_i[c].address = addr;
		ctrl_i[c].wr_data = data;
	endtask

	task automatic random_mon(input logic all_valid);
		for (int c = 0; c < CH; c++)
		begin
			drv_vld[c] = all_valid ? 1'b1 : 1'($urandom % 2);
			drv_data[c] = $urandom & chan_mask(c);
		end
	endtask

	// push drives to the DUT and advance the model by one cycle
	task automatic apply_cycle();
		logic ctrl_wr;
		for (int h = 0; h < HIT; h++)
		begin
			mon_hit_i[h].vld = drv_vld[h];
			mon_hit_i[h].data = drv_data[h][`FM_HIT_DW-1:0];
		end
		for (int s = 0; s < SEG; s++)
		begin
			mon_seg_i[s].vld = drv_vld[HIT+s];
			mon_seg_i[s].data = drv_data[HIT+s][`FM_SEG_DW-1:0];
		end
		for (int c = 0; c < CH; c++)
		begin
			ctrl_wr = ctrl_i[c].enable & ctrl_i[c].wr_enable;
			if (!fill_active)
			begin
				if (ctrl_wr)
					mem_model[c][ctrl_i[c].address] = ctrl_i[c].wr_data & chan_mask(c);
				else if (ctrl_i[c].enable)
				begin
					rd_pend[c] = 1'b1; // old word even if captured now
					rd_exp[c] = mem_model[c][ctrl_i[c].address];
				end
				if (drv_vld[c] && !freeze_i[c] && !ctrl_wr)
				begin
					mem_model[c][ptr_model[c]] = drv_data[c];
					ptr_model[c] = (ptr_model[c] + 1) % DEPTH; // circular
				end
			end
		end
	endtask

	task automatic run_mon(input int cycles, input logic frz, input logic all_valid);
		for (int i = 0; i < cycles; i++)
		begin
			tick();
			clear_ctrl();
			freeze_i = frz ? '1 : '0;
			random_mon(all_valid);
			apply_cycle();
		end
	endtask

	// back to back reads on even cycles, random extra reads in between
	task automatic read_all();
		for (int i = 0; i < 2 * DEPTH; i++)
		begin
			tick();
			clear_ctrl();
			random_mon(1'b0);
			for (int c = 0; c < CH; c++)
			begin
				if (i % 2 == 0)
					set_ctrl(c, 1'b0, ADDR_W'(i / 2), 32'h0);
				else if ($urandom % 2 == 0)
					set_ctrl(c, 1'b0, ADDR_W'($urandom % DEPTH), 32'h0);
			end
			apply_cycle();
		end
	endtask

	task automatic wait_ack();
		int n;
		n = 0;
		while (init_ack_o !== 1'b1)
		begin
			if (n == TIMEOUT)
			begin
				$display("timeout: init_ack_o never rose while init_req_i was held");
				fail_run();
			end
			tick();
			clear_ctrl();
			apply_cycle();
			n++;
		end
	endtask

	initial
	begin
		void'($urandom(32'hf01a));
		pass_chk = 1'b0;
		fill_active = 1'b0;
		axi_reset_n = 1'b0;
		freeze_i = '1;
		init_req_i = 1'b0;
		clear_ctrl();
		for (int c = 0; c < CH; c++)
		begin
			drv_vld[c] = 1'b0;
			drv_data[c] = '0;
			rd_pend[c] = 1'b0;
			rd_exp[c] = '0;
			ptr_model[c] = 0;
			for (int a = 0; a < DEPTH; a++)
				mem_model[c][a] = '0; // unknown until written
		end
		apply_cycle();
		repeat (2) @(posedge spy_clock);
		tick();
		axi_reset_n = 1'b1;
		check_val("init_ack_o", 32'(init_ack_o), 32'h0);
		for (int h = 0; h < HIT; h++)
			check_val($sformatf("pass_hit_o[%0d].vld", h), 32'(pass_hit_o[h].vld), 32'h0);
		for (int s = 0; s < SEG; s++)
			check_val($sformatf("pass_seg_o[%0d].vld", s), 32'(pass_seg_o[s].vld), 32'h0);
		pass_chk = 1'b1;

		// fill first so every location has a known word
		tick();
		init_req_i = 1'b1;
		apply_cycle();
		tick();
		fill_active = 1'b1;
		for (int c = 0; c < CH; c++)
			set_ctrl(c, 1'b0, ADDR_W'(c), 32'h0); // dropped, no reply expected
		apply_cycle();
		wait_ack();
		fill_active = 1'b0;
		for (int c = 0; c < CH; c++)
			for (int a = 0; a < DEPTH; a++)
				mem_model[c][a] = `FM_INIT_PATTERN & chan_mask(c);
		repeat (3)
		begin
			tick();
			check_val("init_ack_o", 32'(init_ack_o), 32'h1); // held with request
			apply_cycle();
		end
		tick();
		init_req_i = 1'b0;
		apply_cycle();
		tick();
		check_val("init_ack_o", 32'(init_ack_o), 32'h0); // one edge after release
		apply_cycle();
		read_all();

		// passthrough while frozen then while recording
		run_mon(12, 1'b1, 1'b0);
		run_mon(12, 1'b0, 1'b0);

		// capture a known count, then words under freeze must not land
		run_mon(6, 1'b0, 1'b1);
		run_mon(5, 1'b1, 1'b1);
		read_all();

		// control writes, some colliding with monitor words
		for (int i = 0; i < 10; i++)
		begin
			tick();
			clear_ctrl();
			freeze_i = '0;
			random_mon(1'b0);
			for (int c = 0; c < CH; c++)
				set_ctrl(c, 1'b1, ADDR_W'($urandom % DEPTH), $urandom);
			apply_cycle();
		end
		run_mon(4, 1'b0, 1'b1); // lands where the pointer stood before the writes
		read_all();

		tick();
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* src.f */
+incdir+hdl
hdl/fm_pkg.sv
hdl/spy_buffer.sv
hdl/spy_mem_init.sv
hdl/fm_data.sv
verif/fm_data_tb.sv

/* Makefile */
# Verilator build and run for the fast-monitor spy bank

VERILATOR ?= verilator
TOP ?= fm_data_tb
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
